//--- calc_types_pkg.sv
package calc_types_pkg;

    // Datapath widths
    localparam int data_w  = 16;              // Operands, results and display
    localparam int digit_w = 4;               // One keypad digit

    // One-hot operator codes as driven by the keypad
    localparam logic [2:0] op_add = 3'b001;
    localparam logic [2:0] op_sub = 3'b010;
    localparam logic [2:0] op_mul = 3'b100;

    // Scale factor applied to an operand before each new digit
    localparam logic [data_w-1:0] radix = data_w'(10);

    // One multiplier iteration per bit of the multiplier operand
    localparam int mul_steps = data_w;

endpackage

//--- calc_fsm_pkg.sv
package calc_fsm_pkg;

    // Controller states
    // Digit entry loops through shift_op, wait_shift and add_digit
    // The final operation runs through exec and wait_exec
    typedef enum logic [2:0] {
        idle_first  = 3'd0,                   // Waiting for first operand keys
        shift_op    = 3'd1,                   // Start operand times ten
        wait_shift  = 3'd2,                   // Wait for the multiplier
        add_digit   = 3'd3,                   // Fold in the pending digit
        idle_second = 3'd4,                   // Waiting for second operand keys
        exec        = 3'd5,                   // Start the selected unit
        wait_exec   = 3'd6,                   // Wait for the unit to finish
        show        = 3'd7                    // Result on display
    } ctrl_state_t;

endpackage

//--- add_sub_unit.sv
module add_sub_unit (
    input  logic                              clk,
    input  logic                              nRST,
    input  logic [calc_types_pkg::data_w-1:0] alu_a,
    input  logic [calc_types_pkg::data_w-1:0] alu_b,
    input  logic                              alu_sub,     // High selects a minus b
    input  logic                              alu_start,
    output logic [calc_types_pkg::data_w-1:0] alu_out,
    output logic                              alu_finish
);

    logic [calc_types_pkg::data_w-1:0] sum_next;

    // Wraps modulo 2^16 in both directions
    assign sum_next = alu_sub ? (alu_a - alu_b) : (alu_a + alu_b);

    // Result register, held until the next start
    always_ff @(posedge clk) begin
        if (alu_start) begin
            alu_out <= sum_next;
        end
    end

    // Finish follows start by exactly one cycle
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            alu_finish <= 1'b0;
        end else begin
            alu_finish <= alu_start;
        end
    end

endmodule

//--- seq_multiplier.sv
module seq_multiplier (
    input  logic                              clk,
    input  logic                              nRST,
    input  logic [calc_types_pkg::data_w-1:0] mul_a,
    input  logic [calc_types_pkg::data_w-1:0] mul_b,
    input  logic                              mul_start,
    output logic [calc_types_pkg::data_w-1:0] mul_out,
    output logic                              mul_finish
);

    logic [calc_types_pkg::data_w-1:0] mcand;                // Shifted left each step
    logic [calc_types_pkg::data_w-1:0] mplier;               // Shifted right each step
    logic [calc_types_pkg::data_w-1:0] acc;                  // Partial product, low half

    logic [$clog2(calc_types_pkg::mul_steps + 1)-1:0] step_cnt;
    logic                                            running;
    logic                                            last_step;

    assign last_step = running && (step_cnt == $bits(step_cnt)'(1));

    // Accumulator is the product once finish is seen
    assign mul_out = acc;

    // Datapath, one bit of the multiplier per cycle
    always_ff @(posedge clk) begin
        if (mul_start) begin
            mcand  <= mul_a;
            mplier <= mul_b;
            acc    <= '0;
        end else if (running) begin
            if (mplier[0]) begin
                acc <= acc + mcand;                          // Upper bits drop off
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Step counter and run flag
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            running    <= 1'b0;
            step_cnt   <= '0;
            mul_finish <= 1'b0;
        end else begin
            mul_finish <= 1'b0;
            if (mul_start) begin
                running  <= 1'b1;
                step_cnt <= $bits(step_cnt)'(calc_types_pkg::mul_steps);
            end else if (running) begin
                step_cnt <= step_cnt - 1'b1;
                if (last_step) begin
                    running    <= 1'b0;                      // Back to idle
                    mul_finish <= 1'b1;                      // Lines up with final add
                end
            end
        end
    end

endmodule

//--- calc_controller.sv
module calc_controller (
    input  logic                               clk,
    input  logic                               nRST,

    // Keypad strobes
    input  logic [calc_types_pkg::digit_w-1:0] keypad_input,
    input  logic                               read_input,
    input  logic [2:0]                         operator_input,
    input  logic                               equal_input,

    // Status and display
    output logic                               busy,
    output logic                               complete,
    output logic [calc_types_pkg::data_w-1:0]  display_output,

    // Add/subtract unit
    output logic [calc_types_pkg::data_w-1:0]  alu_a,
    output logic [calc_types_pkg::data_w-1:0]  alu_b,
    output logic                               alu_sub,
    output logic                               alu_start,
    input  logic [calc_types_pkg::data_w-1:0]  alu_out,
    input  logic                               alu_finish,

    // Shared multiplier
    output logic [calc_types_pkg::data_w-1:0]  mul_a,
    output logic [calc_types_pkg::data_w-1:0]  mul_b,
    output logic                               mul_start,
    input  logic [calc_types_pkg::data_w-1:0]  mul_out,
    input  logic                               mul_finish
);

    calc_fsm_pkg::ctrl_state_t state;

    logic [calc_types_pkg::data_w-1:0]  operand_one;
    logic [calc_types_pkg::data_w-1:0]  operand_two;
    logic                               entry_sel;          // High while building operand two
    logic [2:0]                         op_reg;
    logic [calc_types_pkg::digit_w-1:0] digit_reg;
    logic                               fresh;              // Next digit restarts operand one

    logic [calc_types_pkg::data_w-1:0]  key_ext;
    logic [calc_types_pkg::data_w-1:0]  entry_operand;
    logic [calc_types_pkg::data_w-1:0]  result_value;
    logic                               digit_key;
    logic                               op_key;
    logic                               is_mul;
    logic                               unit_finish;

    assign key_ext = {{(calc_types_pkg::data_w - calc_types_pkg::digit_w){1'b0}}, keypad_input};

    // Only decimal digits and one-hot operators count as key presses
    assign digit_key = read_input && (key_ext < calc_types_pkg::radix);
    assign op_key    = (operator_input == calc_types_pkg::op_add) ||
                       (operator_input == calc_types_pkg::op_sub) ||
                       (operator_input == calc_types_pkg::op_mul);

    assign is_mul        = (op_reg == calc_types_pkg::op_mul);
    assign entry_operand = entry_sel ? operand_two : operand_one;
    assign result_value  = is_mul ? mul_out : alu_out;
    assign unit_finish   = is_mul ? mul_finish : alu_finish;

    assign busy = !((state == calc_fsm_pkg::idle_first)  ||
                    (state == calc_fsm_pkg::idle_second) ||
                    (state == calc_fsm_pkg::show));

    // Unit strobes are decoded from the state, operands come straight from registers
    assign alu_a     = operand_one;
    assign alu_b     = operand_two;
    assign alu_sub   = (op_reg == calc_types_pkg::op_sub);
    assign alu_start = (state == calc_fsm_pkg::exec) && !is_mul;

    assign mul_a     = (state == calc_fsm_pkg::exec) ? operand_one : entry_operand;
    assign mul_b     = (state == calc_fsm_pkg::exec) ? operand_two : calc_types_pkg::radix;
    assign mul_start = (state == calc_fsm_pkg::shift_op) ||
                       ((state == calc_fsm_pkg::exec) && is_mul);

    // Pending digit, consumed in add_digit
    always_ff @(posedge clk) begin
        if (!busy && digit_key) begin
            digit_reg <= keypad_input;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= calc_fsm_pkg::idle_first;
            operand_one    <= '0;
            operand_two    <= '0;
            entry_sel      <= 1'b0;
            op_reg         <= calc_types_pkg::op_add;
            fresh          <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            complete <= 1'b0;                                // One-cycle pulse

            case (state)
                // Show behaves like idle_first with the result already in operand one
                calc_fsm_pkg::idle_first,
                calc_fsm_pkg::show: begin
                    if (digit_key) begin
                        entry_sel <= 1'b0;
                        fresh     <= 1'b0;
                        if (fresh) begin
                            operand_one <= '0;               // New calculation
                        end
                        state <= calc_fsm_pkg::shift_op;
                    end else if (op_key) begin
                        op_reg      <= operator_input;       // Chains on operand one
                        operand_two <= '0;
                        fresh       <= 1'b0;
                        state       <= calc_fsm_pkg::idle_second;
                    end else begin
                        state <= calc_fsm_pkg::idle_first;   // Equal is ignored here
                    end
                end

                calc_fsm_pkg::shift_op: begin
                    state <= calc_fsm_pkg::wait_shift;
                end

                calc_fsm_pkg::wait_shift: begin
                    if (mul_finish) begin
                        state <= calc_fsm_pkg::add_digit;
                    end
                end

                calc_fsm_pkg::add_digit: begin
                    if (entry_sel) begin
                        operand_two <= mul_out + {{(calc_types_pkg::data_w -
                                       calc_types_pkg::digit_w){1'b0}}, digit_reg};
                        state       <= calc_fsm_pkg::idle_second;
                    end else begin
                        operand_one <= mul_out + {{(calc_types_pkg::data_w -
                                       calc_types_pkg::digit_w){1'b0}}, digit_reg};
                        state       <= calc_fsm_pkg::idle_first;
                    end
                end

                // A second operator here is ignored
                calc_fsm_pkg::idle_second: begin
                    if (digit_key) begin
                        entry_sel <= 1'b1;
                        state     <= calc_fsm_pkg::shift_op;
                    end else if (equal_input) begin
                        state <= calc_fsm_pkg::exec;
                    end
                end

                calc_fsm_pkg::exec: begin
                    state <= calc_fsm_pkg::wait_exec;
                end

                calc_fsm_pkg::wait_exec: begin
                    if (unit_finish) begin
                        display_output <= result_value;
                        operand_one    <= result_value;      // Ready for chaining
                        complete       <= 1'b1;
                        fresh          <= 1'b1;
                        state          <= calc_fsm_pkg::show;
                    end
                end

                default: begin
                    state <= calc_fsm_pkg::idle_first;
                end
            endcase
        end
    end

endmodule

//--- calc_top.sv
module calc_top (
    input  logic                               clk,
    input  logic                               nRST,
    input  logic [calc_types_pkg::digit_w-1:0] keypad_input,
    input  logic                               read_input,
    input  logic [2:0]                         operator_input,
    input  logic                               equal_input,
    output logic                               busy,
    output logic                               complete,
    output logic [calc_types_pkg::data_w-1:0]  display_output
);

    logic [calc_types_pkg::data_w-1:0] alu_a;
    logic [calc_types_pkg::data_w-1:0] alu_b;
    logic                              alu_sub;
    logic                              alu_start;
    logic [calc_types_pkg::data_w-1:0] alu_out;
    logic                              alu_finish;

    logic [calc_types_pkg::data_w-1:0] mul_a;
    logic [calc_types_pkg::data_w-1:0] mul_b;
    logic                              mul_start;
    logic [calc_types_pkg::data_w-1:0] mul_out;
    logic                              mul_finish;

    calc_controller ctrl_i (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .busy           (busy),
        .complete       (complete),
        .display_output (display_output),
        .alu_a          (alu_a),
        .alu_b          (alu_b),
        .alu_sub        (alu_sub),
        .alu_start      (alu_start),
        .alu_out        (alu_out),
        .alu_finish     (alu_finish),
        .mul_a          (mul_a),
        .mul_b          (mul_b),
        .mul_start      (mul_start),
        .mul_out        (mul_out),
        .mul_finish     (mul_finish)
    );

    add_sub_unit alu_i (
        .clk        (clk),
        .nRST       (nRST),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_sub    (alu_sub),
        .alu_start  (alu_start),
        .alu_out    (alu_out),
        .alu_finish (alu_finish)
    );

    // Shared by digit entry and the multiply operation
    seq_multiplier mul_i (
        .clk        (clk),
        .nRST       (nRST),
        .mul_a      (mul_a),
        .mul_b      (mul_b),
        .mul_start  (mul_start),
        .mul_out    (mul_out),
        .mul_finish (mul_finish)
    );

endmodule

//--- calc_tb.sv
module calc_tb;

    localparam int key_digit = 0;
    localparam int key_op    = 1;
    localparam int key_equal = 2;

    localparam int num_seqs        = 110;
    localparam int max_seq_cycles  = 340;       // 12 digits, extra keys and one equal
    localparam int directed_cycles = 2600;      // Reset and directed cases
    localparam int cycle_limit     = num_seqs * max_seq_cycles + directed_cycles;

    logic                               clk;
    logic                               nRST;
    logic [calc_types_pkg::digit_w-1:0] keypad_input;
    logic                               read_input;
    logic [2:0]                         operator_input;
    logic                               equal_input;
    logic                               busy;
    logic                               complete;
    logic [calc_types_pkg::data_w-1:0]  display_output;

    integer      seed          = 80;
    int          error_count   = 0;
    int          cycle_cnt     = 0;
    int          complete_seen = 0;
    logic [15:0] last_display  = '0;

    // Calculator model
    logic [15:0] m_op1;
    logic [15:0] m_op2;
    logic [2:0]  m_op;
    logic        m_second;                      // Building operand two
    logic        m_fresh;                       // Next digit restarts operand one
    logic        m_has_result;
    logic [15:0] m_display;
    int          m_results;

    calc_top dut_i (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .busy           (busy),
        .complete       (complete),
        .display_output (display_output)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Run exceeded %0d cycles without finishing", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Completion pulses and display stability sampled mid-cycle
    always @(negedge clk) begin
        if (nRST) begin
            if (complete) begin
                complete_seen = complete_seen + 1;
            end
            if (display_output !== last_display && !complete) begin
                $display("display_output changed without a completed result");
                error_count = error_count + 1;
            end
            last_display = display_output;
        end
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic bit is_one_hot(input logic [2:0] op);
        return (op == calc_types_pkg::op_add) || (op == calc_types_pkg::op_sub) ||
               (op == calc_types_pkg::op_mul);
    endfunction

    function automatic logic [2:0] pick_operator();
        int idx;
        idx = rand_below(3);
        if (idx == 0) begin
            return calc_types_pkg::op_add;
        end else if (idx == 1) begin
            return calc_types_pkg::op_sub;
        end
        return calc_types_pkg::op_mul;
    endfunction

    function automatic int digit_count();
        if (rand_below(8) == 0) begin
            return 5 + rand_below(2);           // Long enough to overflow
        end
        return 1 + rand_below(4);
    endfunction

    // Keys that make the DUT busy on the following cycle
    function automatic bit causes_busy(input int kind, input logic [3:0] d);
        return (kind == key_digit && d < 4'd10) || (kind == key_equal && m_second);
    endfunction

    function automatic void model_key(input int kind, input logic [3:0] d,
                                      input logic [2:0] op);
        logic [15:0] d_ext;
        d_ext = {12'h000, d};
        if (kind == key_digit && d < 4'd10) begin
            if (m_second) begin
                m_op2 = m_op2 * 16'd10 + d_ext;
            end else begin
                if (m_fresh) begin
                    m_op1 = '0;                 // Digit after a result
                end
                m_fresh = 1'b0;
                m_op1   = m_op1 * 16'd10 + d_ext;
            end
        end else if (kind == key_op && !m_second && is_one_hot(op)) begin
            m_op     = op;
            m_op2    = '0;
            m_fresh  = 1'b0;
            m_second = 1'b1;
        end else if (kind == key_equal && m_second) begin
            if (m_op == calc_types_pkg::op_add) begin
                m_display = m_op1 + m_op2;
            end else if (m_op == calc_types_pkg::op_sub) begin
                m_display = m_op1 - m_op2;      // Wraps below zero
            end else begin
                m_display = m_op1 * m_op2;      // Low 16 bits
            end
            m_op1        = m_display;
            m_fresh      = 1'b1;
            m_second     = 1'b0;
            m_has_result = 1'b1;
            m_results    = m_results + 1;
        end
    endfunction

    task automatic wait_ready();
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
    endtask

    task automatic clear_keys();
        read_input     <= 1'b0;
        keypad_input   <= 4'h0;
        operator_input <= 3'b000;
        equal_input    <= 1'b0;
    endtask

    // Any key while busy must be dropped
    task automatic drive_busy_strobe();
        int pick;
        pick = rand_below(3);
        read_input     <= (pick == 0);
        keypad_input   <= 4'(rand_below(16));
        operator_input <= (pick == 1) ? pick_operator() : 3'b000;
        equal_input    <= (pick == 2);
    endtask

    task automatic press_key(input int kind, input logic [3:0] d, input logic [2:0] op);
        bit junk;
        wait_ready();
        @(posedge clk);
        read_input     <= (kind == key_digit);
        keypad_input   <= d;
        operator_input <= (kind == key_op) ? op : 3'b000;
        equal_input    <= (kind == key_equal);
        junk = causes_busy(kind, d) && (rand_below(4) == 0);
        model_key(kind, d, op);
        @(posedge clk);
        if (junk) begin
            drive_busy_strobe();
            @(posedge clk);
        end
        clear_keys();
    endtask

    task automatic maybe_ignored_key();
        int pick;
        int idx;
        if (rand_below(5) == 0) begin
            pick = rand_below(3);
            idx  = rand_below(4);
            if (pick == 0) begin
                press_key(key_digit, 4'(10 + rand_below(6)), 3'b000);
            end else if (pick == 1) begin
                press_key(key_op, 4'h0, (idx == 0) ? 3'b011 : 3'(idx + 4));
            end else if (!m_second) begin
                press_key(key_equal, 4'h0, 3'b000);     // No operator yet
            end else begin
                press_key(key_op, 4'h0, pick_operator());
            end
        end
    endtask

    task automatic enter_number(input int n);
        for (int i = 0; i < n; i++) begin
            maybe_ignored_key();
            press_key(key_digit, 4'(rand_below(10)), 3'b000);
        end
    endtask

    task automatic press_number(input int value);
        int digits[$];
        int v;
        v = value;
        do begin
            digits.push_front(v % 10);
            v = v / 10;
        end while (v > 0);
        foreach (digits[i]) begin
            press_key(key_digit, 4'(digits[i]), 3'b000);
        end
    endtask

    task automatic check_result();
        wait_ready();
        @(posedge clk);
        @(negedge clk);
        if (display_output !== m_display) begin
            $display("ERROR display_output expected %h got %h", m_display, display_output);
            error_count = error_count + 1;
        end
        if (complete_seen != m_results) begin
            $display("ERROR complete count expected %h got %h", m_results, complete_seen);
            error_count = error_count + 1;
        end
        if (complete !== 1'b0) begin
            $display("complete stayed high for more than one cycle");
            error_count = error_count + 1;
        end
    endtask

    initial begin
        clk            = 1'b0;
        nRST           = 1'b0;
        keypad_input   = 4'h0;
        read_input     = 1'b0;
        operator_input = 3'b000;
        equal_input    = 1'b0;
        m_op1          = '0;
        m_op2          = '0;
        m_op           = calc_types_pkg::op_add;
        m_second       = 1'b0;
        m_fresh        = 1'b0;
        m_has_result   = 1'b0;
        m_display      = '0;
        m_results      = 0;

        repeat (3) @(posedge clk);
        nRST <= 1'b1;
        @(negedge clk);
        if (busy !== 1'b0) begin
            $display("ERROR busy expected %h got %h", 1'b0, busy);
            error_count = error_count + 1;
        end
        if (complete !== 1'b0) begin
            $display("ERROR complete expected %h got %h", 1'b0, complete);
            error_count = error_count + 1;
        end
        if (display_output !== 16'h0000) begin
            $display("ERROR display_output expected %h got %h", 16'h0000, display_output);
            error_count = error_count + 1;
        end

        // Equal before any operator, then a wrapping subtraction
        press_key(key_equal, 4'h0, 3'b000);
        press_number(12);
        press_key(key_op, 4'h0, calc_types_pkg::op_sub);
        press_number(345);
        press_key(key_equal, 4'h0, 3'b000);
        check_result();

        // Overflowing entry and product
        press_number(70000);
        press_key(key_op, 4'h0, calc_types_pkg::op_mul);
        press_number(99);
        press_key(key_equal, 4'h0, 3'b000);
        check_result();

        // Chain on the result, then a fresh operand
        press_key(key_op, 4'h0, calc_types_pkg::op_add);
        press_number(5);
        press_key(key_equal, 4'h0, 3'b000);
        check_result();
        press_number(3);
        press_key(key_op, 4'h0, calc_types_pkg::op_sub);
        press_number(1);
        press_key(key_equal, 4'h0, 3'b000);
        check_result();

        for (int seq = 0; seq < num_seqs; seq++) begin
            if (!(m_has_result && rand_below(4) == 0)) begin
                enter_number(digit_count());            // Otherwise chain on the result
            end
            maybe_ignored_key();
            press_key(key_op, 4'h0, pick_operator());
            enter_number(digit_count());
            maybe_ignored_key();
            press_key(key_equal, 4'h0, 3'b000);
            check_result();
        end

        $display("Results %0d, complete pulses %0d, errors %0d",
                 m_results, complete_seen, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
calc_types_pkg.sv
calc_fsm_pkg.sv
add_sub_unit.sv
seq_multiplier.sv
calc_controller.sv
calc_top.sv
calc_tb.sv

//--- Makefile
TOP := calc_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f project.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
